//--- files.f
+incdir+include
logic/force_unit_pkg.sv
logic/pair_if.sv
logic/filter_lane.sv
logic/filter_bank.sv
logic/r2_stage.sv
logic/force_stage.sv
logic/force_eval_unit.sv
tests/force_eval_unit_tb.sv

//--- include/force_unit_params.svh
`ifndef FORCE_UNIT_PARAMS_SVH
`define FORCE_UNIT_PARAMS_SVH

// Lane and data widths
`define NUM_LANES 4
`define COORD_WIDTH 16
`define ID_WIDTH 8

// Box test limit per axis and squared cutoff for the force stage
`define CUTOFF 1024
`define CUTOFF_2 1048576

// Per-lane buffer
`define FILTER_DEPTH 8
`define FILTER_ADDR_WIDTH 3

// Pipeline latencies in cycles
`define R2_LATENCY 2
`define FORCE_LATENCY 2

`endif

//--- logic/filter_bank.sv
`timescale 1ns/100ps
`include "force_unit_params.svh"

module filter_bank
	import force_unit_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [`NUM_LANES-1:0] in_valid,
	input pair_t in_pair [`NUM_LANES],
	output logic [`NUM_LANES-1:0] back_pressure,
	output logic all_empty,
	pair_if.src out
);

	pair_t head [`NUM_LANES];
	pair_t sel;
	logic [`NUM_LANES-1:0] not_empty;
	logic [`NUM_LANES-1:0] pop;

	for (genvar i = 0; i < `NUM_LANES; i++)
	begin : g_lane
		filter_lane lane_i (
			.clk(clk),
			.rst(rst),
			.in_valid(in_valid[i]),
			.in_pair(in_pair[i]),
			.pop(pop[i]),
			.head(head[i]),
			.not_empty(not_empty[i]),
			.full(back_pressure[i])
		);
	end

	// Fixed priority where the lowest set bit wins
	assign pop = not_empty & (~not_empty + 1'b1);

	always_comb
	begin
		sel = head[0];
		for (int i = 0; i < `NUM_LANES; i++)
			if (pop[i])
				sel = head[i];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out.valid <= 1'b0;
		else
			out.valid <= |not_empty;
	end

	always_ff @(posedge clk)
	begin
		out.ref_id <= sel.ref_id;
		out.nbr_id <= sel.nbr_id;
		out.ref_pos <= sel.ref_pos;
		out.nbr_pos <= sel.nbr_pos;
	end

	// Includes the pair still sitting in the output register
	assign all_empty = !(|not_empty) && !out.valid;

endmodule

//--- logic/filter_lane.sv
`timescale 1ns/100ps
`include "force_unit_params.svh"

module filter_lane
	import force_unit_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input pair_t in_pair,
	input logic pop,
	output pair_t head,
	output logic not_empty,
	output logic full
);

	pair_t mem [`FILTER_DEPTH];
	logic [`FILTER_ADDR_WIDTH-1:0] wr_ptr;
	logic [`FILTER_ADDR_WIDTH-1:0] rd_ptr;
	logic [`FILTER_ADDR_WIDTH:0] count;
	logic keep;
	logic wr;

	function automatic coord_t abs_diff(coord_t a, coord_t b);
		return (a > b) ? a - b : b - a;
	endfunction

	// Box test, every axis strictly inside the cutoff
	always_comb
	begin
		keep = (abs_diff(in_pair.ref_pos.x, in_pair.nbr_pos.x) < `CUTOFF) &&
			(abs_diff(in_pair.ref_pos.y, in_pair.nbr_pos.y) < `CUTOFF) &&
			(abs_diff(in_pair.ref_pos.z, in_pair.nbr_pos.z) < `CUTOFF);
	end

	assign wr = in_valid && keep;

	always_ff @(posedge clk)
	begin
		if (wr)
			mem[wr_ptr] <= in_pair;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, pointer wraps
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign full = (count == `FILTER_DEPTH) && !pop; // A slot frees up this cycle when popped

	// Source must hold off while back-pressure is up
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		wr |-> (count < `FILTER_DEPTH) || pop);

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop |-> not_empty);

endmodule

//--- logic/force_eval_unit.sv
`timescale 1ns/100ps
`include "force_unit_params.svh"

module force_eval_unit
	import force_unit_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [`NUM_LANES-1:0] in_valid,
	input pid_t ref_id [`NUM_LANES],
	input pid_t nbr_id [`NUM_LANES],
	input pos_t ref_pos [`NUM_LANES],
	input pos_t nbr_pos [`NUM_LANES],
	output logic [`NUM_LANES-1:0] back_pressure, // Lane FIFO full
	output logic all_empty,
	output logic force_valid,
	output pid_t ref_id_out,
	output pid_t nbr_id_out,
	output force_t force_x,
	output force_t force_y,
	output force_t force_z
);

	pair_t lane_pair [`NUM_LANES];
	logic r2_valid;
	pid_t r2_ref_id;
	pid_t r2_nbr_id;
	disp_t dx;
	disp_t dy;
	disp_t dz;
	r2_t r2;

	pair_if pair_bus ();

	for (genvar i = 0; i < `NUM_LANES; i++)
	begin : g_pack
		assign lane_pair[i] = '{ref_id: ref_id[i], nbr_id: nbr_id[i],
			ref_pos: ref_pos[i], nbr_pos: nbr_pos[i]};
	end

	filter_bank bank_i (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_pair(lane_pair),
		.back_pressure(back_pressure),
		.all_empty(all_empty),
		.out(pair_bus.src)
	);

	r2_stage r2_i (
		.clk(clk),
		.rst(rst),
		.in(pair_bus.dst),
		.r2_valid(r2_valid),
		.ref_id(r2_ref_id),
		.nbr_id(r2_nbr_id),
		.dx(dx),
		.dy(dy),
		.dz(dz),
		.r2(r2)
	);

	force_stage force_i (
		.clk(clk),
		.rst(rst),
		.r2_valid(r2_valid),
		.ref_id_in(r2_ref_id),
		.nbr_id_in(r2_nbr_id),
		.dx(dx),
		.dy(dy),
		.dz(dz),
		.r2(r2),
		.force_valid(force_valid),
		.ref_id(ref_id_out),
		.nbr_id(nbr_id_out),
		.force_x(force_x),
		.force_y(force_y),
		.force_z(force_z)
	);

endmodule

//--- logic/force_stage.sv
`timescale 1ns/100ps
`include "force_unit_params.svh"

module force_stage
	import force_unit_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic r2_valid,
	input pid_t ref_id_in,
	input pid_t nbr_id_in,
	input disp_t dx,
	input disp_t dy,
	input disp_t dz,
	input r2_t r2,
	output logic force_valid,
	output pid_t ref_id,
	output pid_t nbr_id,
	output force_t force_x,
	output force_t force_y,
	output force_t force_z
);

	localparam int SEG_WIDTH = $clog2($bits(r2_t));

	logic [SEG_WIDTH-1:0] seg_next;
	logic [SEG_WIDTH-1:0] seg;
	logic in_cut;
	logic v1;
	pid_t ref_id1;
	pid_t nbr_id1;
	disp_t dx1;
	disp_t dy1;
	disp_t dz1;

	// Leading one of r2 stands in for the exponent of a float
	always_comb
	begin
		seg_next = '0;
		for (int i = 0; i < $bits(r2_t); i++)
			if (r2[i])
				seg_next = SEG_WIDTH'(i);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v1 <= 1'b0;
			force_valid <= 1'b0;
		end
		else
		begin
			v1 <= r2_valid;
			force_valid <= v1;
		end
	end

	always_ff @(posedge clk)
	begin
		seg <= seg_next;
		in_cut <= (r2 < `CUTOFF_2);
		ref_id1 <= ref_id_in;
		nbr_id1 <= nbr_id_in;
		dx1 <= dx;
		dy1 <= dy;
		dz1 <= dz;
		ref_id <= ref_id1;
		nbr_id <= nbr_id1;
		force_x <= in_cut ? force_t'(dx1 >>> seg) : '0; // Zero beyond the cutoff sphere
		force_y <= in_cut ? force_t'(dy1 >>> seg) : '0;
		force_z <= in_cut ? force_t'(dz1 >>> seg) : '0;
	end

endmodule

//--- logic/force_unit_pkg.sv
`include "force_unit_params.svh"

package force_unit_pkg;

	typedef logic [`COORD_WIDTH-1:0] coord_t; // Unsigned fixed point

	typedef struct packed
	{
		coord_t x;
		coord_t y;
		coord_t z;
	} pos_t;

	typedef logic [`ID_WIDTH-1:0] pid_t;

	// One extra bit so a difference of two coordinates never overflows
	typedef logic signed [`COORD_WIDTH:0] disp_t;

	// Sum of three squared displacements
	typedef logic [2*`COORD_WIDTH+2:0] r2_t;

	typedef logic signed [`COORD_WIDTH:0] force_t;

	typedef struct packed
	{
		pid_t ref_id;
		pid_t nbr_id;
		pos_t ref_pos;
		pos_t nbr_pos;
	} pair_t;

endpackage

//--- logic/pair_if.sv
`timescale 1ns/100ps

// One arbitrated pair per valid strobe, no ready
interface pair_if
	import force_unit_pkg::*;
();

	logic valid;
	pid_t ref_id;
	pid_t nbr_id;
	pos_t ref_pos;
	pos_t nbr_pos;

	modport src (output valid, output ref_id, output nbr_id, output ref_pos, output nbr_pos);

	modport dst (input valid, input ref_id, input nbr_id, input ref_pos, input nbr_pos);

endinterface

//--- logic/r2_stage.sv
`timescale 1ns/100ps
`include "force_unit_params.svh"

module r2_stage
	import force_unit_pkg::*;
(
	input logic clk,
	input logic rst,
	pair_if.dst in,
	output logic r2_valid,
	output pid_t ref_id,
	output pid_t nbr_id,
	output disp_t dx,
	output disp_t dy,
	output disp_t dz,
	output r2_t r2
);

	logic v1;
	pid_t ref_id1;
	pid_t nbr_id1;
	disp_t dx1;
	disp_t dy1;
	disp_t dz1;

	// Neighbor minus reference on one axis
	function automatic disp_t axis_diff(coord_t nbr, coord_t ref_c);
		return disp_t'($signed({1'b0, nbr}) - $signed({1'b0, ref_c}));
	endfunction

	function automatic r2_t square(disp_t d);
		logic signed [2*`COORD_WIDTH+1:0] wide;
		wide = d; // Widen before the product
		return r2_t'(wide * wide);
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v1 <= 1'b0;
			r2_valid <= 1'b0;
		end
		else
		begin
			v1 <= in.valid;
			r2_valid <= v1;
		end
	end

	always_ff @(posedge clk)
	begin
		// Stage 1 displacements
		ref_id1 <= in.ref_id;
		nbr_id1 <= in.nbr_id;
		dx1 <= axis_diff(in.nbr_pos.x, in.ref_pos.x);
		dy1 <= axis_diff(in.nbr_pos.y, in.ref_pos.y);
		dz1 <= axis_diff(in.nbr_pos.z, in.ref_pos.z);
		// Stage 2 sum of squares
		ref_id <= ref_id1;
		nbr_id <= nbr_id1;
		dx <= dx1;
		dy <= dy1;
		dz <= dz1;
		r2 <= square(dx1) + square(dy1) + square(dz1);
	end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" && rm -f sim.log && \
verilator --binary --timing --assert --top-module force_eval_unit_tb \
	-f files.f -o force_eval_unit_sim > build.log 2>&1 && \
./obj_dir/force_eval_unit_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "Simulation passed" && exit 0 || \
	{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- tests/force_eval_unit_tb.sv
`timescale 1ns/100ps
`include "force_unit_params.svh"

module force_eval_unit_tb
	import force_unit_pkg::*;
();

	localparam int MAX_CYCLES = 4000; // About six times the stimulus and drain cycles
	localparam int PIPE_DEPTH = `R2_LATENCY + `FORCE_LATENCY;

	// Expected outcome of one driven pair
	typedef struct packed
	{
		logic keep;
		logic in_cut;
		logic [5:0] seg;
		pid_t ref_id;
		pid_t nbr_id;
		force_t fx;
		force_t fy;
		force_t fz;
	} exp_t;

	logic clk;
	logic rst;
	logic [`NUM_LANES-1:0] in_valid;
	pid_t ref_id [`NUM_LANES];
	pid_t nbr_id [`NUM_LANES];
	pos_t ref_pos [`NUM_LANES];
	pos_t nbr_pos [`NUM_LANES];
	logic [`NUM_LANES-1:0] back_pressure;
	logic all_empty;
	logic force_valid;
	pid_t ref_id_out;
	pid_t nbr_id_out;
	force_t force_x;
	force_t force_y;
	force_t force_z;

	exp_t exp_q [`NUM_LANES][$]; // One queue per lane keeps lane order
	logic [5:0] seq [`NUM_LANES];
	int checks;
	int errors;
	int kept;
	int results;
	int cycles;
	bit bp_seen;
	exp_t got;
	int got_lane;

	force_eval_unit dut_i (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.ref_id(ref_id),
		.nbr_id(nbr_id),
		.ref_pos(ref_pos),
		.nbr_pos(nbr_pos),
		.back_pressure(back_pressure),
		.all_empty(all_empty),
		.force_valid(force_valid),
		.ref_id_out(ref_id_out),
		.nbr_id_out(nbr_id_out),
		.force_x(force_x),
		.force_y(force_y),
		.force_z(force_z)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	// Box test, r2, leading-one segment and shifted forces
	function automatic exp_t expect_pair(pid_t rid, pid_t nid, pos_t rp, pos_t np);
		exp_t e;
		int d [3];
		longint r2;
		int seg;
		d[0] = int'(np.x) - int'(rp.x);
		d[1] = int'(np.y) - int'(rp.y);
		d[2] = int'(np.z) - int'(rp.z);
		e.keep = 1'b1;
		r2 = 0;
		for (int a = 0; a < 3; a++)
		begin
			if (((d[a] < 0) ? -d[a] : d[a]) >= `CUTOFF)
				e.keep = 1'b0;
			r2 = r2 + longint'(d[a]) * longint'(d[a]);
		end
		seg = 0;
		for (int b = 0; b < 40; b++)
			if (r2[b])
				seg = b;
		e.in_cut = (r2 < `CUTOFF_2);
		e.seg = 6'(seg);
		e.ref_id = rid;
		e.nbr_id = nid;
		e.fx = e.in_cut ? force_t'(d[0] >>> seg) : '0;
		e.fy = e.in_cut ? force_t'(d[1] >>> seg) : '0;
		e.fz = e.in_cut ? force_t'(d[2] >>> seg) : '0;
		return e;
	endfunction

	function automatic pos_t mk_pos(int x, int y, int z);
		return '{x: coord_t'(x), y: coord_t'(y), z: coord_t'(z)};
	endfunction

	function automatic int near(coord_t c, int spread);
		return int'(c) + int'($urandom_range(2 * spread)) - spread;
	endfunction

	task automatic next_cycle();
		@(negedge clk);
		in_valid = '0;
	endtask

	// Lane number rides in the top two ID bits
	task automatic offer(input int lane, input pos_t rp, input pos_t np, output exp_t e);
		pid_t rid;
		pid_t nid;
		rid = {2'(lane), seq[lane]};
		nid = pid_t'($urandom);
		ref_id[lane] = rid;
		nbr_id[lane] = nid;
		ref_pos[lane] = rp;
		nbr_pos[lane] = np;
		in_valid[lane] = 1'b1;
		seq[lane] = seq[lane] + 1'b1;
		e = expect_pair(rid, nid, rp, np);
		if (e.keep)
		begin
			exp_q[lane].push_back(e);
			kept++;
		end
	endtask

	task automatic offer_random(input int lane, input int spread);
		pos_t rp;
		pos_t np;
		exp_t e;
		if (back_pressure[lane])
			bp_seen = 1'b1; // Lane holds off this cycle
		else
		begin
			rp = mk_pos(int'($urandom_range(62000, 3000)), int'($urandom_range(62000, 3000)),
				int'($urandom_range(62000, 3000)));
			np = mk_pos(near(rp.x, spread), near(rp.y, spread), near(rp.z, spread));
			offer(lane, rp, np, e);
		end
	endtask

	task automatic wait_drain();
		next_cycle();
		while (!all_empty)
			@(negedge clk);
		repeat (PIPE_DEPTH + 1) @(negedge clk); // Pairs still inside r2 and force stages
		@(posedge clk);
		for (int i = 0; i < `NUM_LANES; i++)
			check(exp_q[i].size() == 0,
				$sformatf("lane %0d has %0d results missing", i, exp_q[i].size()));
	endtask

	task automatic finish_test(input int num, input string name, input int err0,
		input int kept0, input int res0);
		wait_drain();
		check(results - res0 == kept - kept0,
			$sformatf("%0d results for %0d kept pairs", results - res0, kept - kept0));
		$display("Test %0d %s: %0d kept pairs, %0d errors", num, name, kept - kept0,
			errors - err0);
	endtask

	// Scoreboard samples away from the active edge
	always @(negedge clk)
	begin
		if (!rst && force_valid)
		begin
			results++;
			got_lane = int'(ref_id_out[`ID_WIDTH-1 -: 2]);
			check(exp_q[got_lane].size() > 0,
				$sformatf("result on lane %0d with none outstanding", got_lane));
			if (exp_q[got_lane].size() > 0)
			begin
				got = exp_q[got_lane].pop_front();
				check(ref_id_out === got.ref_id && nbr_id_out === got.nbr_id,
					$sformatf("ids %0h/%0h, expected %0h/%0h", ref_id_out, nbr_id_out,
					got.ref_id, got.nbr_id));
				check(force_x === got.fx, $sformatf("force_x %0d, expected %0d", force_x, got.fx));
				check(force_y === got.fy, $sformatf("force_y %0d, expected %0d", force_y, got.fy));
				check(force_z === got.fz, $sformatf("force_z %0d, expected %0d", force_z, got.fz));
			end
		end
	end

	initial
	begin
		int err0;
		int kept0;
		int res0;
		exp_t e;
		$timeformat(-9, 1, " ns", 0);
		void'($urandom(85));
		clk = 1'b0;
		rst = 1'b1;
		in_valid = '0;
		checks = 0;
		errors = 0;
		kept = 0;
		results = 0;
		cycles = 0;
		bp_seen = 1'b0;
		for (int i = 0; i < `NUM_LANES; i++)
		begin
			ref_id[i] = '0;
			nbr_id[i] = '0;
			ref_pos[i] = '0;
			nbr_pos[i] = '0;
			seq[i] = '0;
		end

		err0 = errors;
		kept0 = kept;
		res0 = results;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		check(all_empty === 1'b1 && back_pressure === '0 && force_valid === 1'b0,
			"outputs not idle after reset");
		next_cycle();
		offer(0, mk_pos(1000, 1000, 1000), mk_pos(993, 1001, 1000), e);
		// dx -7 dy 1 dz 0 and r2 is 50
		check(e.keep && e.in_cut && e.seg == 6'd5, "reference segment for r2 of 50 is not 5");
		check(e.fx == force_t'(-1) && e.fy == '0 && e.fz == '0, "reference forces of single pair");
		next_cycle();
		while (!force_valid)
			@(negedge clk);
		@(posedge clk);
		finish_test(1, "single pair", err0, kept0, res0);

		err0 = errors;
		kept0 = kept;
		res0 = results;
		next_cycle();
		offer(1, mk_pos(10000, 10000, 10000), mk_pos(11024, 10000, 10000), e);
		check(!e.keep, "x difference of 1024 kept by the reference");
		next_cycle();
		offer(1, mk_pos(10000, 10000, 10000), mk_pos(10000, 8976, 10000), e);
		check(!e.keep, "y difference of 1024 kept by the reference");
		next_cycle();
		offer(2, mk_pos(10000, 10000, 10000), mk_pos(10000, 10000, 15000), e);
		check(!e.keep, "z difference of 5000 kept by the reference");
		next_cycle();
		offer(3, mk_pos(10000, 10000, 10000), mk_pos(8977, 8977, 8977), e); // Shift alone gives -1
		check(e.keep && !e.in_cut && e.fx == '0, "pair outside the sphere has nonzero force");
		finish_test(2, "box filtering", err0, kept0, res0);

		err0 = errors;
		kept0 = kept;
		res0 = results;
		for (int c = 0; c < 300; c++)
		begin
			next_cycle();
			for (int l = 0; l < `NUM_LANES; l++)
				if ($urandom_range(3) == 0)
					offer_random(l, 1200);
		end
		finish_test(3, "random lanes", err0, kept0, res0);

		err0 = errors;
		kept0 = kept;
		res0 = results;
		bp_seen = 1'b0;
		for (int c = 0; c < 150; c++)
		begin
			next_cycle();
			for (int l = 0; l < `NUM_LANES; l++)
				offer_random(l, 600);
		end
		check(bp_seen, "back_pressure never went high under saturation");
		finish_test(4, "saturation", err0, kept0, res0);

		err0 = errors;
		kept0 = kept;
		res0 = results;
		for (int c = 0; c < 20; c++)
		begin
			next_cycle();
			for (int l = 0; l < `NUM_LANES; l++)
				offer_random(l, 900);
		end
		check(all_empty === 1'b0, "all_empty high while pairs are still buffered");
		finish_test(5, "drain", err0, kept0, res0);

		$display("Summary: %0d checks, %0d errors, %0d results", checks, errors, results);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
